/* include/tcm_defs.svh */
`ifndef TCM_DEFS_SVH
`define TCM_DEFS_SVH

// memory geometry and read latency
`define TCM_ADDR_BITS       10
`define TCM_LATENCY         2
`define THREAD_ID_BITS      2

// identity registers
`define CORE_ID_VALUE       32'h527a_ffff
`define CORE_VERSION_VALUE  32'h0001_0000

// host register word offsets
`define REG_CORE_ID         5'h00
`define REG_CORE_VERSION    5'h01
`define REG_CTL_CONTROL     5'h04
`define REG_CTL_STATUS      5'h05

`define RESET_SYNC_STAGES   2

`endif

/* verilog/tcm_pkg.sv */
`default_nettype none

`include "tcm_defs.svh"

package tcm_pkg;

    // memory and instruction word
    typedef logic [31:0]                    word_t;
    typedef logic [`TCM_ADDR_BITS-1:0]      tcm_addr_t;

    // one enable per byte lane
    typedef logic [3:0]                     strb_t;

    typedef logic [31:0]                    pc_t;
    typedef logic [`THREAD_ID_BITS-1:0]     tid_t;

endpackage

`default_nettype wire

/* verilog/ctl_pkg.sv */
`default_nettype none

package ctl_pkg;

    // host register word offset
    typedef logic [4:0]     reg_addr_t;

    // host register data
    typedef logic [31:0]    ctl_data_t;

endpackage

`default_nettype wire

/* verilog/tcm_port_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface tcm_port_if;
    import tcm_pkg::*;

    logic       en;
    strb_t      we;
    tcm_addr_t  addr;
    word_t      din;
    word_t      dout;

    modport requester (
        output en, we, addr, din,
        input  dout
    );

    modport ram (
        input  en, we, addr, din,
        output dout
    );

endinterface

`default_nettype wire

/* verilog/ifetch_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tcm_defs.svh"

module ifetch_port (
    input  var logic            clk,
    input  var logic            reset,
    input  var tcm_pkg::tid_t   ifetch_tid,
    input  var tcm_pkg::pc_t    ifetch_pc,
    input  var logic            ifetch_valid,
    output logic                ifetch_ready,
    output tcm_pkg::tid_t       ifetch_rtid,
    output tcm_pkg::pc_t        ifetch_rpc,
    output tcm_pkg::word_t      ifetch_rinstr,
    output logic                ifetch_rvalid,
    input  var logic            ifetch_rready,
    tcm_port_if.requester       ram
);
    import tcm_pkg::*;

    tid_t   tid_pipe   [`TCM_LATENCY];
    pc_t    pc_pipe    [`TCM_LATENCY];
    logic   valid_pipe [`TCM_LATENCY];
    logic   advance;

    // whole path moves only when the output slot can be freed
    assign advance = !ifetch_rvalid || ifetch_rready;

    // word address from pc, byte bits dropped
    assign ram.en   = advance;
    assign ram.we   = '0;
    assign ram.addr = ifetch_pc[`TCM_ADDR_BITS+1:2];
    assign ram.din  = '0;

    // tags ride alongside the ram output registers
    always_ff @(posedge clk) begin
        if (advance) begin
            tid_pipe[0] <= ifetch_tid;
            pc_pipe[0]  <= ifetch_pc;
            for (int i = 1; i < `TCM_LATENCY; i++) begin
                tid_pipe[i] <= tid_pipe[i-1];
                pc_pipe[i]  <= pc_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TCM_LATENCY; i++) begin
                valid_pipe[i] <= 1'b0;
            end
        end else if (advance) begin
            valid_pipe[0] <= ifetch_valid;
            for (int i = 1; i < `TCM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    assign ifetch_ready  = advance;
    assign ifetch_rtid   = tid_pipe[`TCM_LATENCY-1];
    assign ifetch_rpc    = pc_pipe[`TCM_LATENCY-1];
    assign ifetch_rinstr = ram.dout;
    assign ifetch_rvalid = valid_pipe[`TCM_LATENCY-1];

endmodule

`default_nettype wire

/* verilog/dbus_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tcm_defs.svh"

module dbus_port (
    input  var logic                clk,
    input  var logic                reset,
    input  var tcm_pkg::tcm_addr_t  dbus_addr,
    input  var logic                dbus_read,
    input  var tcm_pkg::strb_t      dbus_wstrb,
    input  var tcm_pkg::word_t      dbus_wdata,
    input  var logic                dbus_valid,
    output logic                    dbus_ready,
    output tcm_pkg::word_t          dbus_rdata,
    output logic                    dbus_rvalid,
    input  var logic                dbus_rready,
    tcm_port_if.requester           ram
);
    import tcm_pkg::*;

    logic   load_pipe [`TCM_LATENCY];
    logic   advance;
    strb_t  write_strb;

    assign advance = !dbus_rvalid || dbus_rready;

    // strobes only for an actual store request
    assign write_strb = (dbus_valid && !dbus_read) ? dbus_wstrb : '0;

    assign ram.en   = advance;
    assign ram.we   = write_strb;
    assign ram.addr = dbus_addr;
    assign ram.din  = dbus_wdata;

    // loads only, stores give no response
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `TCM_LATENCY; i++) begin
                load_pipe[i] <= 1'b0;
            end
        end else if (advance) begin
            load_pipe[0] <= dbus_valid && dbus_read;
            for (int i = 1; i < `TCM_LATENCY; i++) begin
                load_pipe[i] <= load_pipe[i-1];
            end
        end
    end

    assign dbus_ready  = advance;
    assign dbus_rdata  = ram.dout;
    assign dbus_rvalid = load_pipe[`TCM_LATENCY-1];

endmodule

`default_nettype wire

/* verilog/tcm_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tcm_defs.svh"

module tcm_ram (
    input  var logic    clk,
    tcm_port_if.ram     port_a,
    tcm_port_if.ram     port_b
);
    import tcm_pkg::*;

    word_t  mem [0:(1 << `TCM_ADDR_BITS)-1];

    word_t  a_rd;
    word_t  a_out;
    word_t  b_rd;
    word_t  b_out;

    // ------------------------------
    // byte writes, both ports
    // ------------------------------
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (port_a.en && port_a.we[i]) begin
                mem[port_a.addr][8*i +: 8] <= port_a.din[8*i +: 8];
            end
            if (port_b.en && port_b.we[i]) begin
                mem[port_b.addr][8*i +: 8] <= port_b.din[8*i +: 8];
            end
        end
    end

    // ------------------------------
    // reads, no-change on write
    // ------------------------------
    always_ff @(posedge clk) begin
        if (port_a.en) begin
            if (port_a.we == '0) begin
                a_rd <= mem[port_a.addr];
            end
            a_out <= a_rd;
        end
        if (port_b.en) begin
            if (port_b.we == '0) begin
                b_rd <= mem[port_b.addr];
            end
            b_out <= b_rd;
        end
    end

    assign port_a.dout = a_out;
    assign port_b.dout = b_out;

endmodule

`default_nettype wire

/* verilog/ctl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tcm_defs.svh"

module ctl_regs (
    input  var logic                clk,
    input  var logic                reset,
    input  var logic                ctl_wr,
    input  var logic                ctl_rd,
    input  var ctl_pkg::reg_addr_t  ctl_addr,
    input  var ctl_pkg::ctl_data_t  ctl_wdata,
    output ctl_pkg::ctl_data_t      ctl_rdata,
    output logic                    ctl_rvalid,
    output logic                    core_reset
);
    import ctl_pkg::*;

    logic                               run;
    ctl_data_t                          read_value;
    logic [`RESET_SYNC_STAGES-1:0]      reset_sync;

    // ------------------------------
    // run control
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else if (ctl_wr && ctl_addr == `REG_CTL_CONTROL) begin
            run <= ctl_wdata[0];
        end
    end

    // ------------------------------
    // read decode
    // ------------------------------
    always_comb begin
        case (ctl_addr)
            `REG_CORE_ID:      read_value = `CORE_ID_VALUE;
            `REG_CORE_VERSION: read_value = `CORE_VERSION_VALUE;
            `REG_CTL_CONTROL:  read_value = ctl_data_t'(run);
            // status simply mirrors the run bit
            `REG_CTL_STATUS:   read_value = ctl_data_t'(run);
            default:           read_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctl_rd) begin
            ctl_rdata <= read_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_rvalid <= 1'b0;
        end else begin
            ctl_rvalid <= ctl_rd;
        end
    end

    // ------------------------------
    // core reset
    // ------------------------------
    always_ff @(posedge clk) begin
        reset_sync[0] <= ~run;
        for (int i = 1; i < `RESET_SYNC_STAGES; i++) begin
            reset_sync[i] <= reset_sync[i-1];
        end
    end

    // held high while the subsystem is in reset
    always_ff @(posedge clk) begin
        if (reset) begin
            core_reset <= 1'b1;
        end else begin
            core_reset <= reset_sync[`RESET_SYNC_STAGES-1];
        end
    end

endmodule

`default_nettype wire

/* verilog/tcm_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module tcm_subsystem (
    input  var logic                clk,
    input  var logic                reset,

    // instruction fetch
    input  var tcm_pkg::tid_t       ifetch_tid,
    input  var tcm_pkg::pc_t        ifetch_pc,
    input  var logic                ifetch_valid,
    output logic                    ifetch_ready,
    output tcm_pkg::tid_t           ifetch_rtid,
    output tcm_pkg::pc_t            ifetch_rpc,
    output tcm_pkg::word_t          ifetch_rinstr,
    output logic                    ifetch_rvalid,
    input  var logic                ifetch_rready,

    // load/store
    input  var tcm_pkg::tcm_addr_t  dbus_addr,
    input  var logic                dbus_read,
    input  var tcm_pkg::strb_t      dbus_wstrb,
    input  var tcm_pkg::word_t      dbus_wdata,
    input  var logic                dbus_valid,
    output logic                    dbus_ready,
    output tcm_pkg::word_t          dbus_rdata,
    output logic                    dbus_rvalid,
    input  var logic                dbus_rready,

    // host registers
    input  var logic                ctl_wr,
    input  var logic                ctl_rd,
    input  var ctl_pkg::reg_addr_t  ctl_addr,
    input  var ctl_pkg::ctl_data_t  ctl_wdata,
    output ctl_pkg::ctl_data_t      ctl_rdata,
    output logic                    ctl_rvalid,

    output logic                    core_reset
);

    tcm_port_if fetch_port ();
    tcm_port_if data_port ();

    // ------------------------------
    // fetch path on ram port a
    // ------------------------------
    ifetch_port u_ifetch_port (
        .clk           (clk),
        .reset         (reset),
        .ifetch_tid    (ifetch_tid),
        .ifetch_pc     (ifetch_pc),
        .ifetch_valid  (ifetch_valid),
        .ifetch_ready  (ifetch_ready),
        .ifetch_rtid   (ifetch_rtid),
        .ifetch_rpc    (ifetch_rpc),
        .ifetch_rinstr (ifetch_rinstr),
        .ifetch_rvalid (ifetch_rvalid),
        .ifetch_rready (ifetch_rready),
        .ram           (fetch_port.requester)
    );

    // data path on ram port b
    dbus_port u_dbus_port (
        .clk         (clk),
        .reset       (reset),
        .dbus_addr   (dbus_addr),
        .dbus_read   (dbus_read),
        .dbus_wstrb  (dbus_wstrb),
        .dbus_wdata  (dbus_wdata),
        .dbus_valid  (dbus_valid),
        .dbus_ready  (dbus_ready),
        .dbus_rdata  (dbus_rdata),
        .dbus_rvalid (dbus_rvalid),
        .dbus_rready (dbus_rready),
        .ram         (data_port.requester)
    );

    tcm_ram u_tcm_ram (
        .clk    (clk),
        .port_a (fetch_port.ram),
        .port_b (data_port.ram)
    );

    // ------------------------------
    // host side
    // ------------------------------
    ctl_regs u_ctl_regs (
        .clk        (clk),
        .reset      (reset),
        .ctl_wr     (ctl_wr),
        .ctl_rd     (ctl_rd),
        .ctl_addr   (ctl_addr),
        .ctl_wdata  (ctl_wdata),
        .ctl_rdata  (ctl_rdata),
        .ctl_rvalid (ctl_rvalid),
        .core_reset (core_reset)
    );

endmodule

`default_nettype wire

/* tests/tb_tcm_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tcm_defs.svh"

module tb_tcm_subsystem;
    import tcm_pkg::*;
    import ctl_pkg::*;

    localparam int FILL_WORDS  = 1024;
    localparam int RAND_WRITES = 120;
    localparam int RAND_LOADS  = 120;
    localparam int FETCHES     = 120;
    localparam int STRESS_OPS  = 200;
    localparam int NUM_OPS     = FILL_WORDS + RAND_WRITES + RAND_LOADS + FETCHES
                                 + 2 * STRESS_OPS + 20;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 20 + 1000;
    localparam int unsigned SEED   = 49981;

    logic       clk;
    logic       reset;
    tid_t       ifetch_tid;
    pc_t        ifetch_pc;
    logic       ifetch_valid;
    logic       ifetch_ready;
    tid_t       ifetch_rtid;
    pc_t        ifetch_rpc;
    word_t      ifetch_rinstr;
    logic       ifetch_rvalid;
    logic       ifetch_rready;
    tcm_addr_t  dbus_addr;
    logic       dbus_read;
    strb_t      dbus_wstrb;
    word_t      dbus_wdata;
    logic       dbus_valid;
    logic       dbus_ready;
    word_t      dbus_rdata;
    logic       dbus_rvalid;
    logic       dbus_rready;
    logic       ctl_wr;
    logic       ctl_rd;
    reg_addr_t  ctl_addr;
    ctl_data_t  ctl_wdata;
    ctl_data_t  ctl_rdata;
    logic       ctl_rvalid;
    logic       core_reset;

    // reference model and expected responses
    word_t        model [0:FILL_WORDS-1];
    tid_t         exp_tid_q[$];
    pc_t          exp_pc_q[$];
    word_t        exp_instr_q[$];
    int           exp_cycle_q[$];
    word_t        exp_load_q[$];
    int           cycle = 0;
    logic         strict_timing = 1'b0;
    logic         stress_done = 1'b0;
    int unsigned  seed_main  = SEED;
    int unsigned  seed_fetch = SEED + 1;
    int unsigned  seed_data  = SEED + 2;
    int unsigned  seed_ready = SEED + 3;

    tcm_subsystem u_dut (.*);

    always #20 clk = ~clk;

    function automatic int unsigned lcg(inout int unsigned state);
        state = state * 32'd1664525 + 32'd1013904223;
        // upper half is the better random part
        return {state[15:0], state[31:16]};
    endfunction

    function automatic word_t fill_word(input tcm_addr_t a);
        return {a, 6'h2a, ~a, 6'h15};
    endfunction

    // ------------------------------
    // checks
    // ------------------------------
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_pc(input string name, input pc_t actual, input pc_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_tid(input string name, input tid_t actual, input tid_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_ctl(input string name, input ctl_data_t actual,
                             input ctl_data_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error at %0t: %s expected %b, actual %b",
                               $time, name, expected, actual));
        end
    endtask

    // ------------------------------
    // monitor, sampled mid-cycle
    // ------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            cycle = cycle + 1;
            if (ifetch_valid && ifetch_ready) begin
                exp_tid_q.push_back(ifetch_tid);
                exp_pc_q.push_back(ifetch_pc);
                exp_instr_q.push_back(model[ifetch_pc[11:2]]);
                exp_cycle_q.push_back(cycle);
            end
            if (dbus_valid && dbus_ready) begin
                if (dbus_read) begin
                    exp_load_q.push_back(model[dbus_addr]);
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        if (dbus_wstrb[i]) begin
                            model[dbus_addr][8*i +: 8] = dbus_wdata[8*i +: 8];
                        end
                    end
                end
            end
            if (ifetch_rvalid && ifetch_rready) begin
                if (exp_pc_q.size() == 0) begin
                    fail_run("a fetch response arrived with no fetch outstanding");
                end
                check_tid("ifetch_rtid", ifetch_rtid, exp_tid_q.pop_front());
                check_pc("ifetch_rpc", ifetch_rpc, exp_pc_q.pop_front());
                check_word("ifetch_rinstr", ifetch_rinstr, exp_instr_q.pop_front());
                if (strict_timing && cycle - exp_cycle_q[0] != 2) begin
                    fail_run($sformatf("fetch response came %0d cycles after acceptance, not 2",
                                       cycle - exp_cycle_q[0]));
                end
                void'(exp_cycle_q.pop_front());
            end
            if (dbus_rvalid && dbus_rready) begin
                if (exp_load_q.size() == 0) begin
                    fail_run("a load response arrived with no load outstanding");
                end
                check_word("dbus_rdata", dbus_rdata, exp_load_q.pop_front());
            end
        end
    end

    // ------------------------------
    // request drivers
    // ------------------------------
    // each one starts right after a rising edge and returns on the acceptance edge
    task automatic fetch_request(input tid_t tid, input pc_t pc);
        ifetch_tid   <= tid;
        ifetch_pc    <= pc;
        ifetch_valid <= 1'b1;
        @(negedge clk);
        while (!ifetch_ready) @(negedge clk);
        @(posedge clk);
        ifetch_valid <= 1'b0;
    endtask

    task automatic data_request(input tcm_addr_t addr, input logic read, input strb_t strb,
                                input word_t data);
        dbus_addr  <= addr;
        dbus_read  <= read;
        dbus_wstrb <= strb;
        dbus_wdata <= data;
        dbus_valid <= 1'b1;
        @(negedge clk);
        while (!dbus_ready) @(negedge clk);
        @(posedge clk);
        dbus_valid <= 1'b0;
    endtask

    task automatic ctl_write(input reg_addr_t addr, input ctl_data_t data);
        @(posedge clk);
        ctl_wr    <= 1'b1;
        ctl_addr  <= addr;
        ctl_wdata <= data;
        @(posedge clk);
        ctl_wr <= 1'b0;
    endtask

    task automatic ctl_read(input reg_addr_t addr, input ctl_data_t expected);
        @(posedge clk);
        ctl_rd   <= 1'b1;
        ctl_addr <= addr;
        @(posedge clk);
        ctl_rd <= 1'b0;
        @(negedge clk);
        check_bit("ctl_rvalid", ctl_rvalid, 1'b1);
        check_ctl("ctl_rdata", ctl_rdata, expected);
        @(negedge clk);
        check_bit("ctl_rvalid", ctl_rvalid, 1'b0);
    endtask

    // run bit write, then core_reset moves on the third edge after it
    task automatic run_control(input logic run_bit);
        ctl_write(`REG_CTL_CONTROL, ctl_data_t'(run_bit));
        repeat (3) begin
            @(negedge clk);
            check_bit("core_reset", core_reset, run_bit);
        end
        @(negedge clk);
        check_bit("core_reset", core_reset, !run_bit);
        ctl_read(`REG_CTL_CONTROL, ctl_data_t'(run_bit));
        ctl_read(`REG_CTL_STATUS, ctl_data_t'(run_bit));
    endtask

    task automatic fetch_stream(input int count);
        int unsigned r;
        for (int n = 0; n < count; n++) begin
            r = lcg(seed_fetch);
            // words 0 to 511 only, the data stream stays above
            fetch_request(tid_t'(r >> 28), pc_t'(lcg(seed_fetch) & 32'hffff_f7fc));
            repeat (r % 3) @(posedge clk);
        end
    endtask

    task automatic data_stream(input int count);
        int unsigned r;
        for (int n = 0; n < count; n++) begin
            r = lcg(seed_data);
            data_request(tcm_addr_t'(512 + r % 512), r[20], strb_t'(r >> 24),
                         lcg(seed_data));
            repeat ((r >> 12) % 3) @(posedge clk);
        end
    endtask

    task automatic toggle_rready();
        int unsigned r;
        while (!stress_done) begin
            @(posedge clk);
            r = lcg(seed_ready);
            ifetch_rready <= (r % 4) != 0;
            dbus_rready   <= ((r >> 4) % 4) != 0;
        end
    endtask

    task automatic drain();
        while (exp_pc_q.size() != 0 || exp_load_q.size() != 0) @(posedge clk);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog expired before the test sequence completed");
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        int unsigned r;
        clk = 1'b0;
        reset = 1'b1;
        ifetch_tid = '0;
        ifetch_pc = '0;
        ifetch_valid = 1'b0;
        ifetch_rready = 1'b1;
        dbus_addr = '0;
        dbus_read = 1'b0;
        dbus_wstrb = '0;
        dbus_wdata = '0;
        dbus_valid = 1'b0;
        dbus_rready = 1'b1;
        ctl_wr = 1'b0;
        ctl_rd = 1'b0;
        ctl_addr = '0;
        ctl_wdata = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // idle state after reset and identity registers
        @(negedge clk);
        check_bit("ifetch_rvalid", ifetch_rvalid, 1'b0);
        check_bit("dbus_rvalid", dbus_rvalid, 1'b0);
        check_bit("core_reset", core_reset, 1'b1);
        ctl_read(`REG_CORE_ID, `CORE_ID_VALUE);
        ctl_read(`REG_CORE_VERSION, `CORE_VERSION_VALUE);
        ctl_read(5'h1f, '0);

        // full-word fill, then partial writes and loads in a small window
        @(posedge clk);
        for (int a = 0; a < FILL_WORDS; a++) begin
            data_request(tcm_addr_t'(a), 1'b0, 4'hf, fill_word(tcm_addr_t'(a)));
        end
        for (int n = 0; n < RAND_WRITES; n++) begin
            r = lcg(seed_main);
            data_request(tcm_addr_t'(r % 64), 1'b0, strb_t'(r >> 8), lcg(seed_main));
        end
        for (int n = 0; n < RAND_LOADS; n++) begin
            r = lcg(seed_main);
            data_request(tcm_addr_t'(r % 64), 1'b1, strb_t'(r >> 8), '0);
        end
        drain();

        // back-to-back fetches, fixed latency
        strict_timing = 1'b1;
        for (int n = 0; n < FETCHES; n++) begin
            r = lcg(seed_main);
            fetch_request(tid_t'(r >> 28), pc_t'(lcg(seed_main) & 32'hffff_fffc));
        end
        drain();
        strict_timing = 1'b0;

        // both paths under back-pressure
        fork
            begin
                fork
                    fetch_stream(STRESS_OPS);
                    data_stream(STRESS_OPS);
                join
                stress_done = 1'b1;
            end
            toggle_rready();
        join
        @(posedge clk);
        ifetch_rready <= 1'b1;
        dbus_rready   <= 1'b1;
        drain();

        run_control(1'b1);
        run_control(1'b0);

        repeat (4) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/tcm_pkg.sv
verilog/ctl_pkg.sv
verilog/tcm_port_if.sv
verilog/ifetch_port.sv
verilog/dbus_port.sv
verilog/tcm_ram.sv
verilog/ctl_regs.sv
verilog/tcm_subsystem.sv
tests/tb_tcm_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the TCM subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f flist.f \
    --top-module tb_tcm_subsystem -o sim_tcm_subsystem

# the simulator exits non-zero on a fatal check, the log decides the result
./obj_dir/sim_tcm_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"
